/* common/ping_cfg.svh */
`ifndef PING_CFG_SVH
`define PING_CFG_SVH

// number of alert receivers that take part in background pings
`define PING_N_ALERTS 6

// number of escalation senders, pinged in round-robin order
`define PING_N_ESC 4

// width of the wait and timeout counters
`define PING_CNT_DW 16

// width of the alert id drawn from the LFSR
`define PING_ID_DW 3

// the LFSR state word and the entropy input share this width
`define PING_LFSR_DW 32
`define PING_LFSR_SEED 32'h5a3c_96e1

// low bits appended to the mask to stretch the reseed interval
`define PING_RESEED_XBITS 3

`endif

/* common/ping_ctrl_pkg.sv */
`default_nettype none

`include "ping_cfg.svh"

package ping_ctrl_pkg;

  // sequencer states where the controller leaves init once and never comes back
  typedef enum logic [2:0] {
    init,
    alert_wait,
    alert_ping,
    esc_wait,
    esc_ping
  } fsm_state_e;

  // field view of the LFSR word
  // the low bits give the wait period and the next bits the alert id
  typedef struct packed {
    logic [`PING_LFSR_DW-`PING_CNT_DW-`PING_ID_DW-1:0] spare;
    logic [`PING_ID_DW-1:0]                           id;
    logic [`PING_CNT_DW-1:0]                          wait_cyc;
  } lfsr_fields_t;

  // the same 32 bits are shifted as one word and read as fields
  typedef union packed {
    logic [`PING_LFSR_DW-1:0] raw;
    lfsr_fields_t             f;
  } lfsr_word_u;

endpackage

`default_nettype wire

/* common/ping_chan_pkg.sv */
`default_nettype none

`include "ping_cfg.svh"

package ping_chan_pkg;

  // one word for wait values, timeouts, the DV mask and the counter itself
  typedef logic [`PING_CNT_DW-1:0] cnt_t;

  // one request or response bit per alert receiver
  typedef logic [`PING_N_ALERTS-1:0] alert_vec_t;

  // one request or response bit per escalation sender
  typedef logic [`PING_N_ESC-1:0] esc_vec_t;

  // index of the alert receiver under test
  typedef logic [`PING_ID_DW-1:0] alert_id_t;

  // index of the escalation sender under test
  typedef logic [$clog2(`PING_N_ESC)-1:0] esc_id_t;

endpackage

`default_nettype wire

/* ping_timer/ping_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module ping_fsm import ping_ctrl_pkg::*; (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic en_i,
  input  wire logic expired_i,
  input  wire logic id_vld_i,
  input  wire logic alert_ok_i,
  input  wire logic esc_ok_i,
  input  wire logic alert_spur_i,
  input  wire logic esc_spur_i,
  output logic      load_wait_o,
  output logic      load_timeout_o,
  output logic      alert_ping_en_o,
  output logic      esc_ping_en_o,
  output logic      esc_advance_o,
  output logic      alert_ping_fail_o,
  output logic      esc_ping_fail_o
);

  fsm_state_e state_q;
  fsm_state_e state_d;

  ////////////////////////////////////////
  // next state and outputs

  always_comb begin
    state_d         = state_q;
    load_wait_o     = 1'b0;
    load_timeout_o  = 1'b0;
    alert_ping_en_o = 1'b0;
    esc_ping_en_o   = 1'b0;
    esc_advance_o   = 1'b0;
    // an unrequested response fails its class in any state
    alert_ping_fail_o = alert_spur_i;
    esc_ping_fail_o   = esc_spur_i;

    unique case (state_q)
      // idle until software turns pinging on
      init: begin
        if (en_i) begin
          state_d     = alert_wait;
          load_wait_o = 1'b1;
        end
      end
      // random pause before the alert ping
      alert_wait: begin
        if (expired_i) begin
          state_d        = alert_ping;
          load_timeout_o = 1'b1;
        end
      end
      // a disabled alert is not pinged and the slot is given up at once
      alert_ping: begin
        alert_ping_en_o = id_vld_i;
        if (expired_i || alert_ok_i || !id_vld_i) begin
          state_d     = esc_wait;
          load_wait_o = 1'b1;
          // a response in the last cycle still counts as in time
          if (expired_i && id_vld_i && !alert_ok_i) begin
            alert_ping_fail_o = 1'b1;
          end
        end
      end
      // random pause before the escalation ping
      esc_wait: begin
        if (expired_i) begin
          state_d        = esc_ping;
          load_timeout_o = 1'b1;
        end
      end
      // the escalation index moves on whether the ping passed or failed
      esc_ping: begin
        esc_ping_en_o = 1'b1;
        if (expired_i || esc_ok_i) begin
          state_d       = alert_wait;
          load_wait_o   = 1'b1;
          esc_advance_o = 1'b1;
          if (expired_i && !esc_ok_i) begin
            esc_ping_fail_o = 1'b1;
          end
        end
      end
    endcase
  end

  ////////////////////////////////////////
  // state register

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= init;
    end else begin
      state_q <= state_d;
    end
  end

  // only one channel class may be under test at a time
  a_ping_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(alert_ping_en_o && esc_ping_en_o));

endmodule

`default_nettype wire

/* ping_timer/ping_cnt.sv */
`timescale 1ns/10ps
`default_nettype none

module ping_cnt import ping_chan_pkg::*; (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic load_wait_i,
  input  wire logic load_timeout_i,
  input  wire cnt_t wait_cyc_i,
  input  wire cnt_t timeout_cyc_i,
  input  wire cnt_t mask_i,
  output logic      expired_o
);

  cnt_t cnt_q;
  cnt_t load_val;

  // bit 2 keeps at least four cycles between two pings
  // the mask only shortens waits in simulation
  assign load_val = load_wait_i ? ((wait_cyc_i | cnt_t'(3'b100)) & mask_i) : timeout_cyc_i;

  assign expired_o = (cnt_q == '0);

  // a load wins over counting, and the count rests at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (load_wait_i || load_timeout_i) begin
      cnt_q <= load_val;
    end else if (!expired_o) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // the mask must keep the forced bit and the low bits of the wait value
  a_mask_min: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mask_i >= cnt_t'(7));

  // only right-aligned masks give a uniform wait distribution
  a_mask_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot(32'(mask_i) + 32'd1));

endmodule

`default_nettype wire

/* verilog/ping_lfsr.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ping_cfg.svh"

module ping_lfsr import ping_ctrl_pkg::*, ping_chan_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     step_i,
  input  wire cnt_t                     mask_i,
  input  wire logic                     edn_ack_i,
  input  wire logic [`PING_LFSR_DW-1:0] edn_data_i,
  output logic                          edn_req_o,
  output cnt_t                          wait_cyc_o,
  output alert_id_t                     id_o
);

  // x^32 + x^22 + x^2 + x + 1 in right-shift Galois form
  localparam logic [`PING_LFSR_DW-1:0] lfsr_taps = 32'h8020_0003;
  localparam int unsigned reseed_dw = `PING_CNT_DW + `PING_RESEED_XBITS;

  logic [reseed_dw-1:0] reseed_q;
  logic                 reseed_en;
  lfsr_word_u           lfsr_q;
  lfsr_word_u           lfsr_d;
  lfsr_word_u           lfsr_next;
  alert_id_t            id_raw;

  ////////////////////////////////////////
  // reseed timer

  // entropy is requested whenever the timer has run out
  assign edn_req_o = (reseed_q == '0);
  assign reseed_en = edn_req_o & edn_ack_i;

  // the request stays low for mask*8+7 cycles after each acknowledge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reseed_q <= '0;
    end else if (reseed_en) begin
      reseed_q <= {mask_i, {`PING_RESEED_XBITS{1'b1}}};
    end else if (!edn_req_o) begin
      reseed_q <= reseed_q - 1'b1;
    end
  end

  ////////////////////////////////////////
  // LFSR state

  always_comb begin
    lfsr_next.raw = (lfsr_q.raw >> 1) ^ (lfsr_q.raw[0] ? lfsr_taps : '0);
    lfsr_d = lfsr_q;
    if (reseed_en) begin
      lfsr_d.raw = lfsr_next.raw ^ edn_data_i;
    end else if (step_i) begin
      lfsr_d = lfsr_next;
    end
    // entropy could cancel the state, which would lock the LFSR up
    if (lfsr_d.raw == '0) begin
      lfsr_d.raw = `PING_LFSR_SEED;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q.raw <= `PING_LFSR_SEED;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  // ids past the last alert are folded back so that fewer draws are wasted
  assign id_raw     = lfsr_q.f.id;
  assign id_o       = (id_raw >= alert_id_t'(`PING_N_ALERTS)) ?
                      id_raw - alert_id_t'(`PING_N_ALERTS) : id_raw;
  assign wait_cyc_o = lfsr_q.f.wait_cyc;

  a_lfsr_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lfsr_q.raw != '0);

endmodule

`default_nettype wire

/* verilog/ping_target.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ping_cfg.svh"

module ping_target import ping_chan_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       load_id_i,
  input  wire alert_id_t  id_i,
  input  wire alert_vec_t alert_ping_en_i,
  input  wire logic       alert_req_en_i,
  input  wire logic       esc_req_en_i,
  input  wire logic       esc_advance_i,
  input  wire alert_vec_t alert_ping_ok_i,
  input  wire esc_vec_t   esc_ping_ok_i,
  output logic            id_vld_o,
  output alert_vec_t      alert_ping_req_o,
  output esc_vec_t        esc_ping_req_o,
  output logic            alert_ok_o,
  output logic            esc_ok_o,
  output logic            alert_spur_o,
  output logic            esc_spur_o
);

  // the enable mask is widened so that every id value has a bit to index
  localparam int unsigned id_span = 2 ** `PING_ID_DW;

  alert_id_t            id_q;
  esc_id_t              esc_idx_q;
  logic [id_span-1:0]   en_mask;

  ////////////////////////////////////////
  // target selection

  // the id must not move while a ping is out, or the response looks spurious
  // escalation senders are visited strictly in order so each one is reached in bounded time
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q      <= '0;
      esc_idx_q <= '0;
    end else begin
      if (load_id_i) begin
        id_q <= id_i;
      end
      if (esc_advance_i) begin
        if (esc_idx_q == esc_id_t'(`PING_N_ESC - 1)) begin
          esc_idx_q <= '0;
        end else begin
          esc_idx_q <= esc_idx_q + 1'b1;
        end
      end
    end
  end

  assign en_mask  = {{(id_span - `PING_N_ALERTS){1'b0}}, alert_ping_en_i};
  assign id_vld_o = en_mask[id_q];

  ////////////////////////////////////////
  // requests and responses

  // one-hot request vectors that stay all zero outside a ping
  assign alert_ping_req_o = alert_vec_t'(alert_req_en_i) << id_q;
  assign esc_ping_req_o   = esc_vec_t'(esc_req_en_i) << esc_idx_q;

  // a response on the requested bit ends the ping
  assign alert_ok_o = |(alert_ping_ok_i & alert_ping_req_o);
  assign esc_ok_o   = |(esc_ping_ok_i & esc_ping_req_o);

  // any response bit without a request is flagged in the same cycle
  assign alert_spur_o = |(alert_ping_ok_i & ~alert_ping_req_o);
  assign esc_spur_o   = |(esc_ping_ok_i & ~esc_ping_req_o);

  // the sequencer only enables an alert ping for a valid, enabled id
  a_alert_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_req_en_i |-> $onehot(alert_ping_req_o & alert_ping_en_i));

endmodule

`default_nettype wire

/* verilog/ping_timer_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ping_cfg.svh"

module ping_timer_top import ping_chan_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     en_i,
  input  wire alert_vec_t               alert_ping_en_i,
  input  wire cnt_t                     ping_timeout_cyc_i,
  input  wire cnt_t                     wait_cyc_mask_i,
  input  wire alert_vec_t               alert_ping_ok_i,
  input  wire esc_vec_t                 esc_ping_ok_i,
  input  wire logic                     edn_ack_i,
  input  wire logic [`PING_LFSR_DW-1:0] edn_data_i,
  output logic                          edn_req_o,
  output alert_vec_t                    alert_ping_req_o,
  output esc_vec_t                      esc_ping_req_o,
  output logic                          alert_ping_fail_o,
  output logic                          esc_ping_fail_o
);

  // sequencer controls
  logic load_wait;
  logic load_timeout;
  logic alert_req_en;
  logic esc_req_en;
  logic esc_advance;

  // status back to the sequencer
  logic expired;
  logic id_vld;
  logic alert_ok;
  logic esc_ok;
  logic alert_spur;
  logic esc_spur;

  // values drawn from the LFSR
  cnt_t      wait_cyc;
  alert_id_t lfsr_id;

  ping_fsm i_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .en_i              (en_i),
    .expired_i         (expired),
    .id_vld_i          (id_vld),
    .alert_ok_i        (alert_ok),
    .esc_ok_i          (esc_ok),
    .alert_spur_i      (alert_spur),
    .esc_spur_i        (esc_spur),
    .load_wait_o       (load_wait),
    .load_timeout_o    (load_timeout),
    .alert_ping_en_o   (alert_req_en),
    .esc_ping_en_o     (esc_req_en),
    .esc_advance_o     (esc_advance),
    .alert_ping_fail_o (alert_ping_fail_o),
    .esc_ping_fail_o   (esc_ping_fail_o)
  );

  ping_cnt i_cnt (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .load_wait_i    (load_wait),
    .load_timeout_i (load_timeout),
    .wait_cyc_i     (wait_cyc),
    .timeout_cyc_i  (ping_timeout_cyc_i),
    .mask_i         (wait_cyc_mask_i),
    .expired_o      (expired)
  );

  // the LFSR moves on with every counter load so each period draws fresh values
  ping_lfsr i_lfsr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .step_i     (load_wait | load_timeout),
    .mask_i     (wait_cyc_mask_i),
    .edn_ack_i  (edn_ack_i),
    .edn_data_i (edn_data_i),
    .edn_req_o  (edn_req_o),
    .wait_cyc_o (wait_cyc),
    .id_o       (lfsr_id)
  );

  ping_target i_target (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .load_id_i        (load_timeout),
    .id_i             (lfsr_id),
    .alert_ping_en_i  (alert_ping_en_i),
    .alert_req_en_i   (alert_req_en),
    .esc_req_en_i     (esc_req_en),
    .esc_advance_i    (esc_advance),
    .alert_ping_ok_i  (alert_ping_ok_i),
    .esc_ping_ok_i    (esc_ping_ok_i),
    .id_vld_o         (id_vld),
    .alert_ping_req_o (alert_ping_req_o),
    .esc_ping_req_o   (esc_ping_req_o),
    .alert_ok_o       (alert_ok),
    .esc_ok_o         (esc_ok),
    .alert_spur_o     (alert_spur),
    .esc_spur_o       (esc_spur)
  );

endmodule

`default_nettype wire

/* testbench/tb_ping_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ping_cfg.svh"

module tb_ping_timer import ping_chan_pkg::*; ();

  localparam int unsigned timeout_cyc = 12;
  localparam int unsigned wait_mask   = 16'h001f;
  // enough ping slots for the phase that waits on a single enabled alert
  localparam int unsigned n_slots     = 300;
  localparam int unsigned watchdog_ns = n_slots * (wait_mask + timeout_cyc + 2) * 8;

  // one responder mode per test phase
  localparam int m_idle = 0, m_answer = 1, m_only3 = 2, m_silent = 3, m_spur = 4;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic en_i;
  alert_vec_t alert_ping_en_i, alert_ping_ok_i, alert_ping_req_o;
  esc_vec_t esc_ping_ok_i, esc_ping_req_o;
  cnt_t ping_timeout_cyc_i, wait_cyc_mask_i;
  logic edn_ack_i, edn_req_o, alert_ping_fail_o, esc_ping_fail_o;
  logic [`PING_LFSR_DW-1:0] edn_data_i;

  logic any_req, fail_any, alert_prev = 1'b0, esc_prev = 1'b0, edn_acked = 1'b0;
  int mode = m_idle;
  int pass_cnt = 0, fail_cnt = 0, test_fails = 0;
  int run_len = 0, edn_low = 0, pings_done = 0, alert_pings = 0, esc_seen = 0;
  int edn_checked = 0, resp_cnt = 0, resp_delay = 0;
  logic [31:0] rng = 32'h8e4b;

  assign any_req  = |alert_ping_req_o || |esc_ping_req_o;
  assign fail_any = alert_ping_fail_o || esc_ping_fail_o;

  always #4 clk_i = ~clk_i;

  ping_timer_top i_dut (.*);

  // one 32-bit xorshift step per call
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic value_mismatch(input string sig, input logic [31:0] got,
                                input logic [31:0] exp);
    fail_cnt++;
    $display("[FAIL] %s got 0x%h, expected 0x%h at %0t", sig, got, exp, $time);
  endtask

  task automatic flag_problem(input string text);
    fail_cnt++;
    $display("[FAIL] %s at %0t", text, $time);
  endtask

  ////////////////////////////////////////
  // responder and entropy source

  // answers in time unless silent and draws the delay before the request rises
  always @(posedge clk_i) begin
    rng = xorshift(rng);
    alert_ping_ok_i <= '0;
    esc_ping_ok_i   <= '0;
    edn_ack_i       <= 1'b0;
    if (!any_req) begin
      resp_cnt   = 0;
      resp_delay = int'(rng[7:0]) % int'(ping_timeout_cyc_i);
    end else begin
      if (mode != m_silent && mode != m_idle && resp_cnt == resp_delay) begin
        alert_ping_ok_i <= alert_ping_req_o;
        esc_ping_ok_i   <= esc_ping_req_o;
      end
      resp_cnt = resp_cnt + 1;
    end
    // alert 5 is disabled in this phase, so it can never be requested
    if (mode == m_spur && rng[10:8] == 3'd0) begin
      alert_ping_ok_i[5] <= 1'b1;
    end
    // no escalation ping can follow an alert ping within one cycle
    if (mode == m_spur && |alert_ping_req_o && rng[12:11] == 2'd0) begin
      esc_ping_ok_i <= 4'b0001;
    end
    if (mode != m_idle && edn_req_o && !edn_ack_i && rng[13]) begin
      edn_ack_i  <= 1'b1;
      edn_data_i <= rng;
    end
  end

  // run lengths and event counts for the assertions and the phase control
  always @(posedge clk_i) begin
    run_len    <= any_req ? run_len + 1 : 0;
    edn_low    <= edn_req_o ? 0 : edn_low + 1;
    alert_prev <= |alert_ping_req_o;
    esc_prev   <= |esc_ping_req_o;
    if (run_len != 0 && !any_req) pings_done <= pings_done + 1;
    if (alert_prev && !(|alert_ping_req_o)) alert_pings <= alert_pings + 1;
    if (esc_prev && !(|esc_ping_req_o)) esc_seen <= esc_seen + 1;
    if (edn_req_o && edn_ack_i) edn_acked <= 1'b1;
    if (edn_acked && edn_req_o && edn_low != 0) edn_checked <= edn_checked + 1;
  end

  ////////////////////////////////////////
  // checks

  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode == m_idle |-> !any_req && !fail_any && edn_req_o) pass_cnt++;
    else flag_problem("request, fail or missing entropy request while disabled");
  a_req_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({alert_ping_req_o, esc_ping_req_o})) pass_cnt++;
    else flag_problem("more than one ping request high");
  a_req_enabled: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (alert_ping_req_o & ~alert_ping_en_i) == '0) pass_cnt++;
    else value_mismatch("alert_ping_req_o", $sampled(alert_ping_req_o), '0);
  a_only3: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode == m_only3 && |alert_ping_req_o |-> alert_ping_req_o == 6'b001000) pass_cnt++;
    else value_mismatch("alert_ping_req_o", $sampled(alert_ping_req_o), 32'h8);
  // round-robin order is derived from the number of finished escalation pings
  a_esc_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(|esc_ping_req_o) |-> esc_ping_req_o == esc_vec_t'(1 << (esc_seen % 4))) pass_cnt++;
    else value_mismatch("esc_ping_req_o", $sampled(esc_ping_req_o),
                        1 << ($sampled(esc_seen) % 4));
  a_len_silent: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode == m_silent && $fell(any_req) |-> run_len == ping_timeout_cyc_i + 1) pass_cnt++;
    else value_mismatch("request length", $sampled(run_len), ping_timeout_cyc_i + 1);
  a_fail_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode == m_silent && fail_any |-> any_req && run_len == ping_timeout_cyc_i) pass_cnt++;
    else flag_problem("timeout fail outside the last request cycle");
  a_fail_seen: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode == m_silent && $fell(any_req) |-> $past(fail_any)) pass_cnt++;
    else flag_problem("unanswered ping ended without a fail pulse");
  a_no_fail: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode == m_answer || mode == m_only3 |-> !fail_any) pass_cnt++;
    else flag_problem("fail raised although every ping was answered");
  a_drop_after_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |(alert_ping_ok_i & alert_ping_req_o) || |(esc_ping_ok_i & esc_ping_req_o)
    |=> !any_req) pass_cnt++;
    else flag_problem("request still high after a matching response");
  a_spur_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |(alert_ping_ok_i & ~alert_ping_req_o) |-> alert_ping_fail_o) pass_cnt++;
    else value_mismatch("alert_ping_fail_o", $sampled(alert_ping_fail_o), 1);
  a_spur_esc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |(esc_ping_ok_i & ~esc_ping_req_o) |-> esc_ping_fail_o) pass_cnt++;
    else value_mismatch("esc_ping_fail_o", $sampled(esc_ping_fail_o), 1);
  a_edn_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_req_o && edn_ack_i |=> !edn_req_o) pass_cnt++;
    else value_mismatch("edn_req_o", $sampled(edn_req_o), 0);
  // the reseed reload is the mask with three set bits appended
  a_edn_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    edn_acked && $rose(edn_req_o) |-> edn_low == wait_cyc_mask_i * 8 + 7) pass_cnt++;
    else value_mismatch("edn_req_o low time", $sampled(edn_low), wait_cyc_mask_i * 8 + 7);

  ////////////////////////////////////////
  // phase control

  // returns right after an edge at which no request was high
  task automatic wait_quiet();
    do @(posedge clk_i); while (any_req);
  endtask

  // returns once n more pings have ended, counting only alert pings if asked
  task automatic run_pings(input int n, input bit alert_only);
    int target;
    target = alert_only ? alert_pings + n : pings_done + n;
    while ((alert_only ? alert_pings : pings_done) < target) begin
      @(posedge clk_i);
    end
  endtask

  task automatic finish_phase(input string name);
    $display("test %-8s finished with %0d failed checks", name, fail_cnt - test_fails);
    test_fails = fail_cnt;
  endtask

  initial begin
    rst_ni = 1'b0;
    en_i = 1'b0;
    alert_ping_en_i = '1;
    alert_ping_ok_i = '0;
    esc_ping_ok_i = '0;
    ping_timeout_cyc_i = cnt_t'(timeout_cyc);
    wait_cyc_mask_i = cnt_t'(wait_mask);
    edn_ack_i = 1'b0;
    edn_data_i = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (50) @(posedge clk_i);
    finish_phase("idle");
    en_i <= 1'b1;
    mode <= m_answer;
    run_pings(8, 1'b0);
    finish_phase("answer");
    // only alert 3 may be pinged and the other draws are dropped at once
    wait_quiet();
    alert_ping_en_i <= 6'b001000;
    mode <= m_only3;
    run_pings(4, 1'b1);
    finish_phase("only3");
    wait_quiet();
    alert_ping_en_i <= '1;
    mode <= m_silent;
    run_pings(8, 1'b0);
    finish_phase("timeout");
    wait_quiet();
    alert_ping_en_i <= 6'b011111;
    mode <= m_spur;
    run_pings(6, 1'b0);
    finish_phase("spurious");
    wait (edn_checked >= 2);
    finish_phase("entropy");
    $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns before all tests finished", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/ping_ctrl_pkg.sv
common/ping_chan_pkg.sv
ping_timer/ping_fsm.sv
ping_timer/ping_cnt.sv
verilog/ping_lfsr.sv
verilog/ping_target.sv
verilog/ping_timer_top.sv
testbench/tb_ping_timer.sv

/* Bender.yml */
package:
  name: ping_timer

sources:
  - include_dirs:
      - common
    files:
      - common/ping_ctrl_pkg.sv
      - common/ping_chan_pkg.sv
      - ping_timer/ping_fsm.sv
      - ping_timer/ping_cnt.sv
      - verilog/ping_lfsr.sv
      - verilog/ping_target.sv
      - verilog/ping_timer_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_ping_timer.sv
